// File: hw/cpuPkg.sv
/* Shared types and constants for the four-stage RV32I core.
   Only word loads and stores exist. Opcodes outside this list decode as no-ops. */
`default_nettype none

package cpuPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdT;
  typedef logic [6:0]  opcodeT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra,
    aluPassB
  } aluOpT;

  typedef enum logic [2:0] {
    brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
  } brCondT;

  localparam wordT pcReset    = 32'h0000_0000;
  // addi x0, x0, 0
  localparam wordT nopInst    = 32'h0000_0013;
  localparam wordT ebreakInst = 32'h0010_0073;

  localparam opcodeT opLui    = 7'b0110111;
  localparam opcodeT opAuipc  = 7'b0010111;
  localparam opcodeT opJal    = 7'b1101111;
  localparam opcodeT opJalr   = 7'b1100111;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opLoad   = 7'b0000011;
  localparam opcodeT opStore  = 7'b0100011;
  localparam opcodeT opImm    = 7'b0010011;
  localparam opcodeT opReg    = 7'b0110011;
  localparam opcodeT opSystem = 7'b1110011;

  typedef struct packed {
    logic valid;
    wordT pc;
    wordT inst;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    wordT   pc;
    regIdT  rs1;
    regIdT  rs2;
    // zero unless the instruction writes a nonzero register
    regIdT  rd;
    wordT   rs1Val;
    wordT   rs2Val;
    wordT   imm;
    aluOpT  aluOp;
    brCondT brCond;
    logic   useImm;
    logic   usePc;
    logic   regWen;
    logic   isLoad;
    logic   isStore;
    logic   isJump;
    logic   isJalr;
    logic   isEbreak;
  } idExT;

  typedef struct packed {
    logic  valid;
    wordT  pc;
    regIdT rd;
    logic  regWen;
    // alu result, link address, or memory address
    wordT  result;
    wordT  storeData;
    logic  isLoad;
    logic  isStore;
    logic  isEbreak;
  } exMwT;

  typedef struct packed {
    wordT  pc;
    regIdT rd;
    logic  regWen;
    wordT  data;
  } retireT;

endpackage

`default_nettype wire

// File: hw/regFile.sv
/* 32 x 32 register file with x0 tied to zero.
   A write and a read of the same register in one cycle return the new data. */
`default_nettype none

module regFile import cpuPkg::*; (
  input  wire        clk,
  input  wire        arstN,
  input  wire regIdT rs1Addr,
  input  wire regIdT rs2Addr,
  output wordT       rs1Data,
  output wordT       rs2Data,
  input  wire        wen,
  input  wire regIdT rd,
  input  wire wordT  wdata
);

  wordT regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through so decode sees the writeback of this cycle
  assign rs1Data = (rs1Addr == '0) ? '0 :
                   (wen && rd == rs1Addr) ? wdata : regs[rs1Addr];
  assign rs2Data = (rs2Addr == '0) ? '0 :
                   (wen && rd == rs2Addr) ? wdata : regs[rs2Addr];

endmodule

`default_nettype wire

// File: hw/fetchStage.sv
/* Program counter and fetch/decode register.
   Instruction memory must answer combinationally in the same cycle.
   Hold or halt freezes both the pc and the fetched entry. */
`default_nettype none

module fetchStage import cpuPkg::*; (
  input  wire       clk,
  input  wire       arstN,
  input  wire       hold,
  input  wire       halted,
  input  wire       redirect,
  input  wire wordT redirectPc,
  output wordT      imemAddr,
  input  wire wordT imemData,
  output ifIdT      ifId
);

  wordT pc;
  wordT nextPc;

  assign imemAddr = pc;

  // redirect from execute wins over sequential fetch
  assign nextPc = redirect ? redirectPc : pc + 32'd4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc   <= pcReset;
      ifId <= '{valid: 1'b0, pc: pcReset, inst: nopInst};
    end else if (!hold && !halted) begin
      pc <= nextPc;
      if (redirect) begin
        // squash the instruction fetched behind the taken control transfer
        ifId <= '{valid: 1'b0, pc: pc, inst: nopInst};
      end else begin
        ifId <= '{valid: 1'b1, pc: pc, inst: imemData};
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
/* Instruction decoder and decode/execute register.
   Unknown opcodes become no-ops that still retire. Funct3 of loads and stores is ignored. */
`default_nettype none

module decodeStage import cpuPkg::*; (
  input  wire        clk,
  input  wire        arstN,
  input  wire        hold,
  input  wire        flush,
  input  wire ifIdT  ifId,
  output regIdT      rs1Addr,
  output regIdT      rs2Addr,
  input  wire wordT  rs1Data,
  input  wire wordT  rs2Data,
  output idExT       idEx
);

  wordT       inst;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immU;
  wordT       immJ;
  logic [2:0] funct3;
  logic       funct7b5;
  logic       writesRd;
  idExT       dec;

  function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
    aluOpT op;
    case (f3)
      3'b000:  op = alt ? aluSub : aluAdd;
      3'b001:  op = aluSll;
      3'b010:  op = aluSlt;
      3'b011:  op = aluSltu;
      3'b100:  op = aluXor;
      3'b101:  op = alt ? aluSra : aluSrl;
      3'b110:  op = aluOr;
      default: op = aluAnd;
    endcase
    return op;
  endfunction

  assign inst     = ifId.inst;
  assign funct3   = inst[14:12];
  assign funct7b5 = inst[30];
  assign rs1Addr  = inst[19:15];
  assign rs2Addr  = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    writesRd   = 1'b0;
    dec.valid  = ifId.valid & ~flush;
    dec.pc     = ifId.pc;
    dec.rs1    = rs1Addr;
    dec.rs2    = rs2Addr;
    dec.rs1Val = rs1Data;
    dec.rs2Val = rs2Data;
    dec.aluOp  = aluAdd;
    dec.brCond = brNone;
    case (inst[6:0])
      opLui: begin
        dec.aluOp  = aluPassB;
        dec.useImm = 1'b1;
        dec.imm    = immU;
        writesRd   = 1'b1;
      end
      opAuipc: begin
        dec.usePc  = 1'b1;
        dec.useImm = 1'b1;
        dec.imm    = immU;
        writesRd   = 1'b1;
      end
      opJal: begin
        dec.usePc  = 1'b1;
        dec.useImm = 1'b1;
        dec.imm    = immJ;
        dec.isJump = 1'b1;
        writesRd   = 1'b1;
      end
      opJalr: begin
        dec.useImm = 1'b1;
        dec.imm    = immI;
        dec.isJump = 1'b1;
        dec.isJalr = 1'b1;
        writesRd   = 1'b1;
      end
      opBranch: begin
        dec.imm = immB;
        case (funct3)
          3'b000:  dec.brCond = brEq;
          3'b001:  dec.brCond = brNe;
          3'b100:  dec.brCond = brLt;
          3'b101:  dec.brCond = brGe;
          3'b110:  dec.brCond = brLtu;
          3'b111:  dec.brCond = brGeu;
          default: dec.brCond = brNone;
        endcase
      end
      opLoad: begin
        dec.useImm = 1'b1;
        dec.imm    = immI;
        dec.isLoad = 1'b1;
        writesRd   = 1'b1;
      end
      opStore: begin
        dec.useImm  = 1'b1;
        dec.imm     = immS;
        dec.isStore = 1'b1;
      end
      opImm: begin
        // only srai uses the funct7 bit among immediate ops
        dec.aluOp  = aluFromFunct(funct3, funct3 == 3'b101 && funct7b5);
        dec.useImm = 1'b1;
        dec.imm    = immI;
        writesRd   = 1'b1;
      end
      opReg: begin
        dec.aluOp = aluFromFunct(funct3, funct7b5);
        writesRd  = 1'b1;
      end
      opSystem: begin
        dec.isEbreak = (inst == ebreakInst);
      end
      default: begin
      end
    endcase
    dec.regWen = writesRd & (inst[11:7] != 5'd0);
    dec.rd     = dec.regWen ? inst[11:7] : 5'd0;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;
    end else if (!hold) begin
      idEx <= dec;
    end
  end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
/* Forwarding, ALU, branch resolution and execute/memory register.
   Only the memory-stage writeback is forwarded; older writes arrive via the
   register file. Taken branches and jumps redirect fetch one cycle later. */
`default_nettype none

module executeStage import cpuPkg::*; (
  input  wire        clk,
  input  wire        arstN,
  input  wire        hold,
  input  wire idExT  idEx,
  input  wire        wbWen,
  input  wire regIdT wbRd,
  input  wire wordT  wbData,
  output logic       redirect,
  output wordT       redirectPc,
  output exMwT       exMw
);

  wordT rs1Fwd;
  wordT rs2Fwd;
  wordT opA;
  wordT opB;
  wordT aluRes;
  wordT pcPlus4;
  wordT pcPlusImm;
  logic taken;
  exMwT nextExMw;

  // memory-stage value overrides the one read in decode
  assign rs1Fwd = (wbWen && wbRd != '0 && wbRd == idEx.rs1) ? wbData : idEx.rs1Val;
  assign rs2Fwd = (wbWen && wbRd != '0 && wbRd == idEx.rs2) ? wbData : idEx.rs2Val;

  assign opA = idEx.usePc ? idEx.pc : rs1Fwd;
  assign opB = idEx.useImm ? idEx.imm : rs2Fwd;

  always_comb begin
    case (idEx.aluOp)
      aluAdd:  aluRes = opA + opB;
      aluSub:  aluRes = opA - opB;
      aluAnd:  aluRes = opA & opB;
      aluOr:   aluRes = opA | opB;
      aluXor:  aluRes = opA ^ opB;
      aluSlt:  aluRes = {31'd0, $signed(opA) < $signed(opB)};
      aluSltu: aluRes = {31'd0, opA < opB};
      aluSll:  aluRes = opA << opB[4:0];
      aluSrl:  aluRes = opA >> opB[4:0];
      aluSra:  aluRes = wordT'($signed(opA) >>> opB[4:0]);
      default: aluRes = opB;
    endcase
  end

  always_comb begin
    case (idEx.brCond)
      brEq:    taken = (rs1Fwd == rs2Fwd);
      brNe:    taken = (rs1Fwd != rs2Fwd);
      brLt:    taken = ($signed(rs1Fwd) < $signed(rs2Fwd));
      brGe:    taken = ($signed(rs1Fwd) >= $signed(rs2Fwd));
      brLtu:   taken = (rs1Fwd < rs2Fwd);
      brGeu:   taken = (rs1Fwd >= rs2Fwd);
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4   = idEx.pc + 32'd4;
  // jal target equals this sum too, since its alu inputs are pc and imm
  assign pcPlusImm = idEx.pc + idEx.imm;

  assign redirect   = idEx.valid & ~hold & (idEx.isJump | taken);
  assign redirectPc = idEx.isJalr ? {aluRes[31:1], 1'b0} : pcPlusImm;

  always_comb begin
    nextExMw           = '0;
    nextExMw.valid     = idEx.valid;
    nextExMw.pc        = idEx.pc;
    nextExMw.rd        = idEx.rd;
    nextExMw.regWen    = idEx.regWen;
    nextExMw.result    = idEx.isJump ? pcPlus4 : aluRes;
    nextExMw.storeData = rs2Fwd;
    nextExMw.isLoad    = idEx.isLoad;
    nextExMw.isStore   = idEx.isStore;
    nextExMw.isEbreak  = idEx.isEbreak;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMw <= '0;
    end else if (!hold) begin
      exMw <= nextExMw;
    end
  end

endmodule

`default_nettype wire

// File: hw/memStage.sv
/* Wishbone classic data master, writeback, retire port and halt.
   Word access only, so wbSel is always all ones. Back-to-back accesses get
   one idle cycle between bus cycles. Nothing retires after ebreak. */
`default_nettype none

module memStage import cpuPkg::*; (
  input  wire        clk,
  input  wire        arstN,
  input  wire exMwT  exMw,
  output logic       hold,
  output logic       wbCyc,
  output logic       wbStb,
  output logic       wbWe,
  output wordT       wbAdr,
  output wordT       wbDatW,
  output logic [3:0] wbSel,
  input  wire        wbAck,
  input  wire wordT  wbDatR,
  output logic       wbWen,
  output regIdT      wbRd,
  output wordT       wbData,
  output logic       retireValid,
  output retireT     retire,
  output logic       halted
);

  logic memReq;
  logic ackNow;
  logic ackSeen;
  logic haltReg;

  assign memReq = exMw.valid & (exMw.isLoad | exMw.isStore) & ~haltReg;

  // ackSeen forces cyc low for one cycle after every completed transfer
  assign wbCyc  = memReq & ~ackSeen;
  assign wbStb  = wbCyc;
  assign wbWe   = wbCyc & exMw.isStore;
  assign wbAdr  = exMw.result;
  assign wbDatW = exMw.storeData;
  assign wbSel  = 4'b1111;

  assign ackNow = wbCyc & wbAck;
  assign hold   = memReq & ~ackNow;

  assign retireValid = exMw.valid & ~haltReg & ~hold;
  assign wbWen       = retireValid & exMw.regWen;
  assign wbRd        = exMw.rd;
  assign wbData      = exMw.isLoad ? wbDatR : exMw.result;

  // visible in the cycle ebreak sits here, sticky afterwards
  assign halted = haltReg | (exMw.valid & exMw.isEbreak);

  always_comb begin
    retire.pc     = exMw.pc;
    retire.rd     = exMw.rd;
    retire.regWen = exMw.regWen;
    retire.data   = exMw.regWen ? wbData : '0;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackSeen <= 1'b0;
      haltReg <= 1'b0;
    end else begin
      ackSeen <= ackNow;
      if (halted) begin
        haltReg <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rvCore.sv
/* Four-stage in-order RV32I core: fetch, decode, execute, memory/writeback.
   Instruction memory is a combinational read port; data goes over Wishbone classic.
   A stalled bus access freezes every earlier stage. */
`default_nettype none

module rvCore import cpuPkg::*; (
  input  wire        clk,
  input  wire        arstN,
  output wordT       imemAddr,
  input  wire wordT  imemData,
  output logic       wbCyc,
  output logic       wbStb,
  output logic       wbWe,
  output wordT       wbAdr,
  output wordT       wbDatW,
  output logic [3:0] wbSel,
  input  wire        wbAck,
  input  wire wordT  wbDatR,
  output logic       retireValid,
  output retireT     retire,
  output logic       halted
);

  ifIdT  ifId;
  idExT  idEx;
  exMwT  exMw;
  regIdT rs1Addr;
  regIdT rs2Addr;
  wordT  rs1Data;
  wordT  rs2Data;
  logic  hold;
  logic  redirect;
  wordT  redirectPc;
  // writeback bundle, shared by register file and forwarding
  logic  wbWen;
  regIdT wbRd;
  wordT  wbData;

  fetchStage uFetch (
    .clk, .arstN, .hold, .halted, .redirect, .redirectPc,
    .imemAddr, .imemData, .ifId
  );

  decodeStage uDecode (
    .clk, .arstN, .hold, .flush(redirect), .ifId,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data, .idEx
  );

  regFile uRegFile (
    .clk, .arstN, .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .wen(wbWen), .rd(wbRd), .wdata(wbData)
  );

  executeStage uExecute (
    .clk, .arstN, .hold, .idEx, .wbWen, .wbRd, .wbData,
    .redirect, .redirectPc, .exMw
  );

  memStage uMem (
    .clk, .arstN, .exMw, .hold,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbSel, .wbAck, .wbDatR,
    .wbWen, .wbRd, .wbData, .retireValid, .retire, .halted
  );

endmodule

`default_nettype wire

// File: include/rvIss.svh
/* Architectural RV32I model for the core testbench, included inside the testbench module.
   Reads instructions from the array imem of the including scope. Word loads and stores
   only. Data memory is 256 words indexed by address bits 9:2. */
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

wordT        issRegs [32];
wordT        issMem  [256];
wordT        issPc;
logic        issHalted;
// memory access of the last stepped instruction
logic        issIsMem;
logic        issMemWe;
wordT        issMemAddr;
wordT        issMemWData;

// initial data memory content that differs at every word address
function automatic wordT fillWord(input int unsigned idx);
  return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000;
endfunction

function automatic void issReset();
  for (int i = 0; i < 32; i++) begin
    issRegs[i] = '0;
  end
  for (int i = 0; i < 256; i++) begin
    issMem[i] = fillWord(i);
  end
  issPc       = pcReset;
  issHalted   = 1'b0;
  issIsMem    = 1'b0;
  issMemWe    = 1'b0;
  issMemAddr  = '0;
  issMemWData = '0;
endfunction

// integer op selected by funct3 where alt picks sub or sra
function automatic wordT aluRef(input logic [2:0] f3, input logic alt, input wordT a,
                                input wordT b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// execute one instruction at issPc and return its expected retire record
function automatic retireT issStep();
  wordT       inst;
  wordT       rs1v;
  wordT       rs2v;
  wordT       immI;
  wordT       immS;
  wordT       immB;
  wordT       immU;
  wordT       immJ;
  wordT       addr;
  wordT       nextPc;
  wordT       value;
  logic       writes;
  logic       take;
  logic [2:0] f3;
  regIdT      rd;
  retireT     rec;
  inst     = imem[issPc[9:2]];
  f3       = inst[14:12];
  rd       = inst[11:7];
  rs1v     = issRegs[inst[19:15]];
  rs2v     = issRegs[inst[24:20]];
  immI     = {{20{inst[31]}}, inst[31:20]};
  immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  immB     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  immU     = {inst[31:12], 12'h000};
  immJ     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  nextPc   = issPc + 32'd4;
  value    = '0;
  writes   = 1'b0;
  take     = 1'b0;
  issIsMem = 1'b0;
  issMemWe = 1'b0;
  case (inst[6:0])
    opLui: begin
      writes = 1'b1;
      value  = immU;
    end
    opAuipc: begin
      writes = 1'b1;
      value  = issPc + immU;
    end
    opJal: begin
      writes = 1'b1;
      value  = issPc + 32'd4;
      nextPc = issPc + immJ;
    end
    opJalr: begin
      writes = 1'b1;
      value  = issPc + 32'd4;
      nextPc = (rs1v + immI) & ~32'd1;
    end
    opBranch: begin
      case (f3)
        3'b000:  take = (rs1v == rs2v);
        3'b001:  take = (rs1v != rs2v);
        3'b100:  take = ($signed(rs1v) < $signed(rs2v));
        3'b101:  take = ($signed(rs1v) >= $signed(rs2v));
        3'b110:  take = (rs1v < rs2v);
        3'b111:  take = (rs1v >= rs2v);
        default: take = 1'b0;
      endcase
      if (take) begin
        nextPc = issPc + immB;
      end
    end
    opLoad: begin
      addr       = rs1v + immI;
      writes     = 1'b1;
      value      = issMem[addr[9:2]];
      issIsMem   = 1'b1;
      issMemAddr = addr;
    end
    opStore: begin
      addr              = rs1v + immS;
      issMem[addr[9:2]] = rs2v;
      issIsMem          = 1'b1;
      issMemWe          = 1'b1;
      issMemAddr        = addr;
      issMemWData       = rs2v;
    end
    opImm:  value = aluRef(f3, f3 == 3'b101 && inst[30], rs1v, immI);
    opReg:  value = aluRef(f3, inst[30], rs1v, rs2v);
    default: begin
    end
  endcase
  if (inst[6:0] == opImm || inst[6:0] == opReg) begin
    writes = 1'b1;
  end
  if (inst == ebreakInst) begin
    issHalted = 1'b1;
  end
  // writes to x0 retire as if nothing was written
  rec.pc     = issPc;
  rec.regWen = writes && rd != 5'd0;
  rec.rd     = rec.regWen ? rd : 5'd0;
  rec.data   = rec.regWen ? value : '0;
  if (rec.regWen) begin
    issRegs[rd] = value;
  end
  issPc = nextPc;
  return rec;
endfunction

`endif

// File: sim/tbCore.sv
/* Testbench for the four-stage RV32I core. Runs sim/prog.hex, checks every retirement
   against the reference model and every Wishbone data access for stability.
   The expected retirement count belongs to that program and must follow any edit of it. */
`default_nettype none

module tbCore import cpuPkg::*; ();

  localparam int progWords       = 39;
  localparam int expectedRetires = 43;
  localparam int quietCycles     = 10;

  logic        clk = 1'b0;
  logic        arstN;
  wordT        imemAddr;
  wordT        imemData;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  wordT        wbAdr;
  wordT        wbDatW;
  logic [3:0]  wbSel;
  logic        wbAck = 1'b0;
  wordT        wbDatR = '0;
  logic        retireValid;
  retireT      retire;
  logic        halted;

  wordT        imem [256];
  wordT        dmem [256];
  logic        reqOpen = 1'b0;
  int unsigned ackWait = 0;
  // request snapshot for the stability check
  logic        busOpen = 1'b0;
  wordT        busAdr = '0;
  logic        busWe = 1'b0;
  wordT        busDat = '0;
  int unsigned retireCount = 0;
  retireT      expRet;

  `include "rvIss.svh"

  rvCore u_dut (
    .clk, .arstN, .imemAddr, .imemData,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbSel, .wbAck, .wbDatR,
    .retireValid, .retire, .halted
  );

  always #4 clk = ~clk;

  // combinational instruction ROM
  assign imemData = imem[imemAddr[9:2]];

  task automatic failNow();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input wordT got, input wordT want);
    if (got !== want) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
      failNow();
    end
  endtask

  task automatic checkResetState();
    checkEq("retireValid", 32'(retireValid), 32'd0);
    checkEq("wbCyc", 32'(wbCyc), 32'd0);
    checkEq("wbStb", 32'(wbStb), 32'd0);
    checkEq("wbWe", 32'(wbWe), 32'd0);
    checkEq("halted", 32'(halted), 32'd0);
    checkEq("imemAddr", imemAddr, pcReset);
  endtask

  // Wishbone slave with 0 to 3 extra wait cycles per request
  always @(posedge clk) begin
    if (!arstN) begin
      wbAck   <= 1'b0;
      reqOpen = 1'b0;
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fillWord(i);
      end
    end else if (wbAck) begin
      // master samples ack at this edge
      wbAck   <= 1'b0;
      reqOpen = 1'b0;
      if (wbWe) begin
        dmem[wbAdr[9:2]] <= wbDatW;
      end
    end else if (wbCyc && wbStb) begin
      if (!reqOpen) begin
        reqOpen = 1'b1;
        ackWait = $urandom % 4;
      end
      if (ackWait == 0) begin
        wbAck  <= 1'b1;
        wbDatR <= dmem[wbAdr[9:2]];
      end else begin
        ackWait = ackWait - 1;
      end
    end
  end

  // master signals must hold from request to ack
  always @(negedge clk) begin
    if (arstN && wbCyc) begin
      checkEq("wbStb", 32'(wbStb), 32'd1);
      checkEq("wbSel", 32'(wbSel), 32'hf);
      if (!busOpen) begin
        busOpen = 1'b1;
        busAdr  = wbAdr;
        busWe   = wbWe;
        busDat  = wbDatW;
      end else begin
        checkEq("wbAdr", wbAdr, busAdr);
        checkEq("wbWe", 32'(wbWe), 32'(busWe));
        checkEq("wbDatW", wbDatW, busDat);
      end
      if (wbAck) begin
        busOpen = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (!arstN) begin
      issReset();
      retireCount = 0;
    end else if (retireValid) begin
      if (issHalted) begin
        $display("instruction at pc 0x%08h retired after ebreak", retire.pc);
        failNow();
      end else begin
        expRet = issStep();
        retireCount++;
        checkEq("retire.pc", retire.pc, expRet.pc);
        checkEq("retire.rd", 32'(retire.rd), 32'(expRet.rd));
        checkEq("retire.regWen", 32'(retire.regWen), 32'(expRet.regWen));
        checkEq("retire.data", retire.data, expRet.data);
        // loads and stores retire in their ack cycle
        if (issIsMem) begin
          checkEq("wbCyc", 32'(wbCyc), 32'd1);
          checkEq("wbAck", 32'(wbAck), 32'd1);
          checkEq("wbAdr", wbAdr, issMemAddr);
          checkEq("wbWe", 32'(wbWe), 32'(issMemWe));
          if (issMemWe) begin
            checkEq("wbDatW", wbDatW, issMemWData);
          end
        end
        if (issHalted) begin
          checkEq("halted", 32'(halted), 32'd1);
        end
      end
    end
  end

  initial begin
    repeat (20 * progWords * 5) @(posedge clk);
    $display("timeout, the core did not reach ebreak in time");
    failNow();
  end

  initial begin
    void'($urandom(32'h6ed8));
    arstN = 1'b0;
    $readmemh("sim/prog.hex", imem);
    repeat (5) begin
      @(negedge clk);
      checkResetState();
    end
    @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkResetState();
    wait (halted === 1'b1);
    // nothing may retire once halted
    repeat (quietCycles) @(posedge clk);
    if (retireCount == expectedRetires && issHalted) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d instructions retired, %0d expected", retireCount, expectedRetires);
      failNow();
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
hw/cpuPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memStage.sv
hw/rvCore.sv
sim/tbCore.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbCore -f filelist.f -o simCore > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }
./obj_dir/simCore > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "testbench reported a failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

// File: sim/prog.hex
// one instruction word per line, starting at address 0x00
// each line shows the word in hex, then its address and assembly
123450B7 // 00 lui   x1, 0x12345
67808093 // 04 addi  x1, x1, 0x678
FFB00113 // 08 addi  x2, x0, -5
002081B3 // 0c add   x3, x1, x2
40118233 // 10 sub   x4, x3, x1
40125293 // 14 srai  x5, x4, 1
00425313 // 18 srli  x6, x4, 4
001223B3 // 1c slt   x7, x4, x1
00123433 // 20 sltu  x8, x4, x1
0060C4B3 // 24 xor   x9, x1, x6
00001517 // 28 auipc x10, 1
10000593 // 2c addi  x11, x0, 0x100
0015A023 // 30 sw    x1, 0(x11)
0095A223 // 34 sw    x9, 4(x11)
0005A603 // 38 lw    x12, 0(x11)
00C606B3 // 3c add   x13, x12, x12
00300713 // 40 addi  x14, x0, 3
0045A803 // 44 lw    x16, 4(x11)
010787B3 // 48 add   x15, x15, x16
FFF70713 // 4c addi  x14, x14, -1
FE071AE3 // 50 bne   x14, x0, 0x44
00070463 // 54 beq   x14, x0, 0x5c
00100A13 // 58 addi  x20, x0, 1
00747463 // 5c bgeu  x8, x7, 0x64
00C000EF // 60 jal   x1, 0x6c
00F5A423 // 64 sw    x15, 8(x11)
0100006F // 68 jal   x0, 0x78
00A2E8B3 // 6c or    x17, x5, x10
0068F933 // 70 and   x18, x17, x6
00008067 // 74 jalr  x0, 0(x1)
0085A983 // 78 lw    x19, 8(x11)
00799B33 // 7c sll   x22, x19, x7
00024463 // 80 blt   x4, x0, 0x88
00900B93 // 84 addi  x23, x0, 9
0165A623 // 88 sw    x22, 12(x11)
00C5AC03 // 8c lw    x24, 12(x11)
00100073 // 90 ebreak
00000013 // 94 nop
00000013 // 98 nop
